/* hw/aduli_pkg.sv */
package aduli_pkg;

    // led chain geometry.
    localparam int NUM_LEDS = 50;
    localparam int LED_ADDR_WIDTH = $clog2(NUM_LEDS);
    localparam int BIT_SEL_WIDTH = $clog2(LED_ADDR_WIDTH);

    // camera side.
    localparam int NUM_SPOTS = 4;
    localparam int BRIGHT_WIDTH = 8;

    // samples at or above this level count as a lit led.
    localparam int BRIGHT_THRESHOLD = 128;

    typedef logic [LED_ADDR_WIDTH-1:0] led_addr_t;
    typedef logic [BIT_SEL_WIDTH-1:0] bit_sel_t;
    typedef logic [BRIGHT_WIDTH-1:0] brightness_t;

    // one camera frame, one brightness sample per tracked spot.
    typedef struct packed {
        brightness_t [NUM_SPOTS-1:0] bright;
    } spot_frame_t;

    // decoded led address seen by each spot.
    typedef struct packed {
        led_addr_t [NUM_SPOTS-1:0] addr;
    } spot_addr_set_t;

    // top level sequencer.
    typedef enum logic [1:0] {
        DISPLAY        = 2'd0,
        SHOW_CALIB_LED = 2'd1,
        RUN_CALIB_STEP = 2'd2
    } aduli_state_t;

    // one capture and decode step.
    typedef enum logic [1:0] {
        STEP_IDLE       = 2'd0,
        STEP_REQUEST    = 2'd1,
        STEP_WAIT_FRAME = 2'd2,
        STEP_DECODE     = 2'd3
    } step_state_t;

    // serial led chain shifter.
    typedef enum logic [1:0] {
        CHAIN_IDLE  = 2'd0,
        CHAIN_SHIFT = 2'd1,
        CHAIN_LATCH = 2'd2
    } chain_state_t;

endpackage

/* hw/aduli_fsm.sv */
`timescale 1ns/1ps

module aduli_fsm (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                start,
    input  logic                led_display_valid,
    input  logic                calibration_step_going,
    input  logic                calibration_step_ready,
    output aduli_pkg::bit_sel_t led_addr_bit_sel,
    output logic                led_addr_bit_sel_start,
    output logic                calibration_start,
    output logic                calibration_first,
    output logic                busy,
    output logic                calibration_done
);

    import aduli_pkg::*;

    aduli_state_t state;

    // set once the step fsm has picked up the current start.
    logic step_started;

    // the chain may finish before the step fsm is ready.
    logic display_valid_seen;

    assign busy = (state != DISPLAY);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= DISPLAY;
            led_addr_bit_sel <= '0;
            led_addr_bit_sel_start <= 1'b0;
            calibration_start <= 1'b0;
            calibration_first <= 1'b0;
            calibration_done <= 1'b0;
            step_started <= 1'b0;
            display_valid_seen <= 1'b0;
        end else begin
            led_addr_bit_sel_start <= 1'b0;
            calibration_done <= 1'b0;

            case (state)
                DISPLAY: begin
                    if (start) begin
                        led_addr_bit_sel <= '0;
                        led_addr_bit_sel_start <= 1'b1;
                        calibration_first <= 1'b1;
                        display_valid_seen <= 1'b0;
                        state <= SHOW_CALIB_LED;
                    end
                end

                SHOW_CALIB_LED: begin
                    if (led_display_valid) begin
                        display_valid_seen <= 1'b1;
                    end

                    if ((display_valid_seen || led_display_valid) && calibration_step_ready) begin
                        calibration_start <= 1'b1;
                        step_started <= 1'b0;
                        display_valid_seen <= 1'b0;
                        state <= RUN_CALIB_STEP;
                    end
                end

                RUN_CALIB_STEP: begin
                    if (calibration_step_going) begin
                        // handshake seen, drop the held request.
                        calibration_start <= 1'b0;
                        calibration_first <= 1'b0;
                        step_started <= 1'b1;
                    end else if (step_started && calibration_step_ready) begin
                        step_started <= 1'b0;
                        if (led_addr_bit_sel == bit_sel_t'(LED_ADDR_WIDTH - 1)) begin
                            calibration_done <= 1'b1;
                            state <= DISPLAY;
                        end else begin
                            led_addr_bit_sel <= led_addr_bit_sel + 1'b1;
                            led_addr_bit_sel_start <= 1'b1;
                            state <= SHOW_CALIB_LED;
                        end
                    end
                end

                default: begin
                    state <= DISPLAY;
                end
            endcase
        end
    end

endmodule

/* hw/led_chain_driver.sv */
`timescale 1ns/1ps

module led_chain_driver (
    input  logic                clk_in,
    input  logic                rst_in,
    input  aduli_pkg::bit_sel_t led_addr_bit_sel,
    input  logic                led_addr_bit_sel_start,
    output logic                led_data,
    output logic                led_clk,
    output logic                led_latch,
    output logic                led_display_valid
);

    import aduli_pkg::*;

    chain_state_t state;

    // the led index counts down to zero as bits go out.
    led_addr_t led_idx;
    led_addr_t next_idx;

    // bit select is captured so the pattern cannot change mid shift.
    bit_sel_t bit_sel_q;

    assign next_idx = led_idx - 1'b1;

    always_ff @(posedge clk_in) begin
        if (led_addr_bit_sel_start && (state == CHAIN_IDLE)) begin
            led_idx <= led_addr_t'(NUM_LEDS - 1);
            bit_sel_q <= led_addr_bit_sel;
        end else if ((state == CHAIN_SHIFT) && led_clk && (led_idx != '0)) begin
            led_idx <= next_idx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= CHAIN_IDLE;
            led_data <= 1'b0;
            led_clk <= 1'b0;
            led_latch <= 1'b0;
            led_display_valid <= 1'b0;
        end else begin
            case (state)
                CHAIN_IDLE: begin
                    led_latch <= 1'b0;
                    led_display_valid <= 1'b0;
                    led_clk <= 1'b0;
                    if (led_addr_bit_sel_start) begin
                        // farthest led goes out first.
                        led_data <= 1'(led_addr_t'(NUM_LEDS - 1) >> led_addr_bit_sel);
                        state <= CHAIN_SHIFT;
                    end else begin
                        led_data <= 1'b0;
                    end
                end

                CHAIN_SHIFT: begin
                    if (!led_clk) begin
                        led_clk <= 1'b1;
                    end else begin
                        led_clk <= 1'b0;
                        if (led_idx == '0) begin
                            led_data <= 1'b0;
                            led_latch <= 1'b1;
                            led_display_valid <= 1'b1;
                            state <= CHAIN_LATCH;
                        end else begin
                            led_data <= next_idx[bit_sel_q];
                        end
                    end
                end

                CHAIN_LATCH: begin
                    led_latch <= 1'b0;
                    led_display_valid <= 1'b0;
                    state <= CHAIN_IDLE;
                end

                default: begin
                    state <= CHAIN_IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/calibration_step_fsm.sv */
`timescale 1ns/1ps

module calibration_step_fsm (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      calibration_start,
    input  logic                      calibration_first,
    input  aduli_pkg::bit_sel_t       led_addr_bit_sel,
    input  logic                      frame_valid,
    input  aduli_pkg::spot_frame_t    spot_frame,
    output logic                      capture_req,
    output logic                      calibration_step_going,
    output logic                      calibration_step_ready,
    output aduli_pkg::spot_addr_set_t spot_addrs
);

    import aduli_pkg::*;

    step_state_t state;

    // per spot lit flag for the frame on the bus.
    logic [NUM_SPOTS-1:0] spot_lit;

    always_comb begin
        for (int s = 0; s < NUM_SPOTS; s++) begin
            spot_lit[s] = (spot_frame.bright[s] >= BRIGHT_THRESHOLD);
        end
    end

    // decode is the handoff cycle, the new bit is already in spot_addrs.
    assign calibration_step_ready = (state == STEP_IDLE) || (state == STEP_DECODE);
    assign calibration_step_going = (state == STEP_REQUEST) || (state == STEP_WAIT_FRAME);
    assign capture_req = (state == STEP_REQUEST);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= STEP_IDLE;
            spot_addrs <= '0;
        end else begin
            case (state)
                STEP_IDLE, STEP_DECODE: begin
                    if (calibration_start) begin
                        // a new calibration starts from a clean address.
                        if (calibration_first) begin
                            spot_addrs <= '0;
                        end
                        state <= STEP_REQUEST;
                    end else begin
                        state <= STEP_IDLE;
                    end
                end

                STEP_REQUEST: begin
                    state <= STEP_WAIT_FRAME;
                end

                STEP_WAIT_FRAME: begin
                    // the camera may take any number of cycles.
                    if (frame_valid) begin
                        for (int s = 0; s < NUM_SPOTS; s++) begin
                            spot_addrs.addr[s][led_addr_bit_sel] <= spot_lit[s];
                        end
                        state <= STEP_DECODE;
                    end
                end

                default: begin
                    state <= STEP_IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/aduli_top.sv */
`timescale 1ns/1ps

module aduli_top (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      start,
    input  logic                      frame_valid,
    input  aduli_pkg::spot_frame_t    spot_frame,
    output logic                      led_data,
    output logic                      led_clk,
    output logic                      led_latch,
    output logic                      capture_req,
    output logic                      busy,
    output logic                      calibration_done,
    output aduli_pkg::spot_addr_set_t spot_addrs
);

    import aduli_pkg::*;

    bit_sel_t led_addr_bit_sel;
    logic     led_addr_bit_sel_start;
    logic     led_display_valid;
    logic     calibration_start;
    logic     calibration_first;
    logic     calibration_step_going;
    logic     calibration_step_ready;

    aduli_fsm aduli_fsm_inst (
        .clk_in                 (clk_in),
        .rst_in                 (rst_in),
        .start                  (start),
        .led_display_valid      (led_display_valid),
        .calibration_step_going (calibration_step_going),
        .calibration_step_ready (calibration_step_ready),
        .led_addr_bit_sel       (led_addr_bit_sel),
        .led_addr_bit_sel_start (led_addr_bit_sel_start),
        .calibration_start      (calibration_start),
        .calibration_first      (calibration_first),
        .busy                   (busy),
        .calibration_done       (calibration_done)
    );

    led_chain_driver led_chain_driver_inst (
        .clk_in                 (clk_in),
        .rst_in                 (rst_in),
        .led_addr_bit_sel       (led_addr_bit_sel),
        .led_addr_bit_sel_start (led_addr_bit_sel_start),
        .led_data               (led_data),
        .led_clk                (led_clk),
        .led_latch              (led_latch),
        .led_display_valid      (led_display_valid)
    );

    calibration_step_fsm calibration_step_fsm_inst (
        .clk_in                 (clk_in),
        .rst_in                 (rst_in),
        .calibration_start      (calibration_start),
        .calibration_first      (calibration_first),
        .led_addr_bit_sel       (led_addr_bit_sel),
        .frame_valid            (frame_valid),
        .spot_frame             (spot_frame),
        .capture_req            (capture_req),
        .calibration_step_going (calibration_step_going),
        .calibration_step_ready (calibration_step_ready),
        .spot_addrs             (spot_addrs)
    );

endmodule

/* testbench/aduli_tb.sv */
`timescale 1ns/1ps

module aduli_tb;

    import aduli_pkg::*;

    localparam int RUNS = 3;
    localparam int DONE_LIMIT = LED_ADDR_WIDTH * (2 * NUM_LEDS + 40);
    localparam int TIMEOUT_CYCLES = RUNS * DONE_LIMIT + 200;

    logic           clk_in;
    logic           rst_in;
    logic           start;
    logic           frame_valid;
    spot_frame_t    spot_frame;
    logic           led_data;
    logic           led_clk;
    logic           led_latch;
    logic           capture_req;
    logic           busy;
    logic           calibration_done;
    spot_addr_set_t spot_addrs;

    // led chain model shifted on each rise of led_clk.
    logic [NUM_LEDS-1:0] chain_shift;
    logic [NUM_LEDS-1:0] latched_pattern;
    logic                led_clk_q;

    // ordering and counts for the calibration in progress.
    logic           latch_pending;
    logic           frame_pending;
    logic           idle_q;
    logic           reset_applied = 1'b0;
    spot_addr_set_t addrs_q;
    int             latch_count;
    int             capture_count;

    spot_addr_set_t expected_addrs = '0;
    int             spot_led [NUM_SPOTS];
    logic [31:0]    lfsr_state = 32'he37a;
    int             error_count = 0;
    int             runs_done = 0;
    int             cycle_count = 0;

    aduli_top aduli_top_inst (.*);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // galois lfsr stepped once per bit taken.
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < count; b++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    // led i is lit in step k when bit k of i is set.
    function automatic logic [NUM_LEDS-1:0] expected_pattern(input int k);
        logic [NUM_LEDS-1:0] pattern;
        for (int i = 0; i < NUM_LEDS; i++) begin
            pattern[i] = ((i >> k) & 1) == 1;
        end
        return pattern;
    endfunction

    task automatic choose_mapping();
        for (int s = 0; s < NUM_SPOTS; s++) begin
            spot_led[s] = int'(take_bits(LED_ADDR_WIDTH) % NUM_LEDS);
            expected_addrs.addr[s] = led_addr_t'(spot_led[s]);
        end
    endtask

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("ERR %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        error_count++;
    endtask

    task automatic finish_run();
        $display("errors: %0d, calibrations completed: %0d", error_count, runs_done);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic wait_for_done(input int run);
        int waited;
        waited = 0;
        while (calibration_done !== 1'b1 && waited < DONE_LIMIT) begin
            @(posedge clk_in);
            #2;
            waited++;
        end
        if (calibration_done === 1'b1) begin
            runs_done++;
        end else begin
            report_failure($sformatf("calibration %0d ended without calibration_done", run));
        end
    endtask

    always @(posedge clk_in) begin
        if (rst_in) begin
            reset_applied <= 1'b1;
            chain_shift <= '0;
            latched_pattern <= '0;
            led_clk_q <= 1'b0;
            latch_pending <= 1'b0;
            frame_pending <= 1'b0;
            idle_q <= 1'b0;
            addrs_q <= '0;
            latch_count <= 0;
            capture_count <= 0;
        end else begin
            led_clk_q <= led_clk;
            idle_q <= !busy;
            addrs_q <= spot_addrs;
            if (led_clk && !led_clk_q) begin
                chain_shift <= {chain_shift[NUM_LEDS-2:0], led_data};
            end
            if (led_latch) begin
                latched_pattern <= chain_shift;
                latch_count <= latch_count + 1;
                latch_pending <= 1'b1;
                frame_pending <= 1'b0;
            end
            if (capture_req) begin
                capture_count <= capture_count + 1;
                latch_pending <= 1'b0;
            end
            if (frame_valid) begin
                frame_pending <= 1'b1;
            end
            // only a start seen while idle opens a new calibration.
            if (start && !busy) begin
                latch_count <= 0;
                capture_count <= 0;
                frame_pending <= 1'b0;
            end
        end
    end

    reset_outputs_low: assert property (@(posedge clk_in) (rst_in && reset_applied) |->
        {busy, calibration_done, capture_req, led_clk, led_latch, led_data, spot_addrs} == '0)
        else report_value(
            "{busy,calibration_done,capture_req,led_clk,led_latch,led_data,spot_addrs}",
            64'h0, 64'({busy, calibration_done, capture_req, led_clk, led_latch, led_data,
            spot_addrs}));

    pattern_matches_bit: assert property (@(posedge clk_in) disable iff (rst_in)
        led_latch |-> chain_shift == expected_pattern(latch_count))
        else report_value("latched led_data pattern", 64'(expected_pattern(latch_count)),
            64'(chain_shift));

    no_extra_latch: assert property (@(posedge clk_in) disable iff (rst_in)
        led_latch |-> latch_count < LED_ADDR_WIDTH)
        else report_failure("led_latch pulsed more often than there are address bits");

    no_extra_capture: assert property (@(posedge clk_in) disable iff (rst_in)
        capture_req |-> capture_count < LED_ADDR_WIDTH)
        else report_failure("capture_req pulsed more often than there are address bits");

    capture_after_latch: assert property (@(posedge clk_in) disable iff (rst_in)
        capture_req |-> latch_pending)
        else report_failure("capture_req came without a led_latch before it");

    latch_after_frame: assert property (@(posedge clk_in) disable iff (rst_in)
        (led_latch && latch_count != 0) |-> frame_pending)
        else report_failure("led_latch for a later bit came before the camera frame");

    first_capture_cleared: assert property (@(posedge clk_in) disable iff (rst_in)
        (capture_req && capture_count == 0) |-> spot_addrs == '0)
        else report_value("spot_addrs at first capture_req", 64'h0, 64'(spot_addrs));

    done_addrs_match: assert property (@(posedge clk_in) disable iff (rst_in)
        calibration_done |-> spot_addrs == expected_addrs)
        else report_value("spot_addrs", 64'(expected_addrs), 64'(spot_addrs));

    done_capture_count: assert property (@(posedge clk_in) disable iff (rst_in)
        calibration_done |-> capture_count == LED_ADDR_WIDTH)
        else report_value("capture_req count", 64'(LED_ADDR_WIDTH), 64'(capture_count));

    idle_addrs_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        (!busy && idle_q) |-> spot_addrs == addrs_q)
        else report_value("spot_addrs while idle", 64'(addrs_q), 64'(spot_addrs));

    // camera model that answers each capture_req after a random delay.
    initial begin
        int delay;
        frame_valid = 1'b0;
        spot_frame = '0;
        forever begin
            @(posedge clk_in);
            #2;
            if (capture_req) begin
                delay = 1 + int'(take_bits(4));
                repeat (delay) @(posedge clk_in);
                #2;
                for (int s = 0; s < NUM_SPOTS; s++) begin
                    if (latched_pattern[spot_led[s]]) begin
                        spot_frame.bright[s] = brightness_t'(160 + take_bits(7) % 96);
                    end else begin
                        spot_frame.bright[s] = brightness_t'(take_bits(7) % 101);
                    end
                end
                frame_valid = 1'b1;
                @(posedge clk_in);
                #2;
                frame_valid = 1'b0;
            end else if (calibration_done) begin
                // an unrequested frame while idle, inverted so a stray write would show.
                for (int s = 0; s < NUM_SPOTS; s++) begin
                    spot_frame.bright[s] = latched_pattern[spot_led[s]] ? brightness_t'(0)
                                                                        : brightness_t'(255);
                end
                frame_valid = 1'b1;
                @(posedge clk_in);
                #2;
                frame_valid = 1'b0;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        report_failure($sformatf("timeout, run still going after %0d cycles", cycle_count));
        finish_run();
    end

    initial begin
        int stray_wait;
        rst_in = 1'b1;
        start = 1'b0;
        repeat (10) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
        for (int run = 0; run < RUNS; run++) begin
            repeat (3) @(posedge clk_in);
            #2;
            choose_mapping();
            start = 1'b1;
            @(posedge clk_in);
            #2;
            start = 1'b0;
            // a second strobe while busy must leave the run untouched.
            stray_wait = 1 + int'(take_bits(8));
            repeat (stray_wait) @(posedge clk_in);
            #2;
            start = 1'b1;
            @(posedge clk_in);
            #2;
            start = 1'b0;
            wait_for_done(run);
        end
        repeat (5) @(posedge clk_in);
        finish_run();
    end

endmodule

/* src.f */
hw/aduli_pkg.sv
hw/aduli_fsm.sv
hw/led_chain_driver.sv
hw/calibration_step_fsm.sv
hw/aduli_top.sv
testbench/aduli_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aduli_tb -f src.f -o aduli_sim \
    && ./obj_dir/aduli_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0
